// ==== verification/execute_stim.txt ====
// unit op use_imm imm pc rs1 rs2 rob pd rd flush_after exp_rd_v exp_pc_select exp_pc_branch
// unit 0 alu 1 mul 2 div 3 br, flush_after 0 means no flush, all values hex
0 00 0 00000000 00000000 00000005 00000007 01 21 01 0 0000000c 0 00000000
0 00 1 fffffff0 00000000 00000100 00000000 02 22 02 0 000000f0 0 00000000
0 01 0 00000000 00000000 00000003 00000005 03 23 03 0 fffffffe 0 00000000
0 02 1 0000001f 00000000 00000001 00000000 04 24 04 0 80000000 0 00000000
0 03 0 00000000 00000000 ffffffff 00000001 05 25 05 0 00000001 0 00000000
0 04 0 00000000 00000000 ffffffff 00000001 06 26 06 0 00000000 0 00000000
0 05 1 ffffffff 00000000 0f0f0f0f 00000000 07 27 07 0 f0f0f0f0 0 00000000
0 06 0 00000000 00000000 80000000 00000004 08 28 08 0 08000000 0 00000000
0 07 1 00000004 00000000 80000000 00000000 09 29 09 0 f8000000 0 00000000
0 08 0 00000000 00000000 12340000 00005678 0a 2a 0a 0 12345678 0 00000000
0 09 1 0000ff00 00000000 12345678 00000000 0b 2b 0b 0 00005600 0 00000000
0 0a 1 abcde000 00000000 00000000 00000000 0c 2c 0c 0 abcde000 0 00000000
0 0b 1 00002000 00001000 00000000 00000000 0d 2d 0d 0 00003000 0 00000000
1 10 0 00000000 00000000 fffffffe 00000003 0e 2e 0e 0 fffffffa 0 00000000
1 11 0 00000000 00000000 80000000 80000000 0f 2f 0f 0 40000000 0 00000000
1 12 0 00000000 00000000 ffffffff ffffffff 10 30 10 0 ffffffff 0 00000000
1 13 0 00000000 00000000 ffffffff ffffffff 11 31 11 0 fffffffe 0 00000000
1 10 0 00000000 00000000 00000007 00000006 12 32 12 1 00000000 0 00000000
1 10 0 00000000 00000000 00000007 00000006 13 33 13 0 0000002a 0 00000000
2 18 0 00000000 00000000 ffffffec 00000003 14 34 14 0 fffffffa 0 00000000
2 1a 0 00000000 00000000 ffffffec 00000003 15 35 15 0 fffffffe 0 00000000
2 19 0 00000000 00000000 ffffffff 00000010 16 36 16 0 0fffffff 0 00000000
2 1b 0 00000000 00000000 ffffffff 00000010 17 37 17 0 0000000f 0 00000000
2 18 0 00000000 00000000 00001234 00000000 18 38 18 0 ffffffff 0 00000000
2 1b 0 00000000 00000000 00001234 00000000 19 39 19 0 00001234 0 00000000
2 18 0 00000000 00000000 80000000 ffffffff 1a 3a 1a 0 80000000 0 00000000
2 1a 0 00000000 00000000 80000000 ffffffff 1b 3b 1b 0 00000000 0 00000000
2 18 0 00000000 00000000 00000064 00000008 1c 3c 1c 1 00000000 0 00000000
2 18 0 00000000 00000000 00000064 00000008 1d 3d 1d 0 0000000c 0 00000000
3 20 0 00000020 00000100 00000005 00000005 1e 3e 1e 0 00000000 1 00000120
3 21 0 00000020 00000100 00000005 00000005 1f 3f 1f 0 00000000 0 00000120
3 22 0 fffffff0 00000200 ffffffff 00000001 00 01 01 0 00000000 1 000001f0
3 23 0 fffffff0 00000200 ffffffff 00000001 01 02 02 0 00000000 0 000001f0
3 24 0 00000008 00000300 ffffffff 00000001 02 03 03 0 00000000 0 00000308
3 25 0 00000008 00000300 ffffffff 00000001 03 04 04 0 00000000 1 00000308
3 26 0 00000100 00000400 00000000 00000000 04 05 05 0 00000404 1 00000500
3 27 0 00000004 00000600 00001001 00000000 05 06 06 0 00000604 1 00001004
// end of list
ff

// ==== compile.f ====
+incdir+include
hw/rv32i_types.sv
hw/fu_alu.sv
hw/fu_mult.sv
hw/fu_div_rem.sv
hw/fu_br.sv
hw/execute.sv
verification/execute_clk_gen.sv
verification/execute_assertions.sv
verification/execute_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the execute stage testbench with Verilator and run it from the project root
verilator --binary --timing --assert -f compile.f --top-module execute_tb -o execute_sim \
    > build.log 2>&1 \
    && ./obj_dir/execute_sim > sim.log 2>&1 \
    && ! grep -q "Verification failed" sim.log \
    && echo "simulation run clean, see sim.log" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== verification/execute_tb.sv ====
`include "rv32i_params.svh"

module execute_tb
    import rv32i_types::*;
();

    localparam int REC_WORDS    = 14;
    localparam int MAX_RECS     = 64;
    localparam int RESET_CYCLES = 4;
    localparam int U_ALU        = 0;
    localparam int U_MUL        = 1;
    localparam int U_DIV        = 2;
    localparam int U_BR         = 3;
    localparam logic [31:0] END_MARK = 32'h000000ff;

    logic                              clk;
    logic                              rst;
    logic                              flush;
    logic [3:0]                        start;
    logic [3:0][`XLEN-1:0]             rs1_v;
    logic [3:0][`XLEN-1:0]             rs2_v;
    decode_info_t [3:0]                di;
    logic [3:0][`ROB_ADDR_WIDTH-1:0]   rob_idx;
    logic [3:0][`PHYS_REG_BITS-1:0]    pd;
    logic [3:0][`ARCH_REG_BITS-1:0]    rd;
    cdb_t [3:0]                        cdb;
    logic [3:1]                        busy;

    logic [31:0] stim [0:REC_WORDS*MAX_RECS-1];
    int          num_recs;
    int          value_errors;
    int          protocol_errors;
    int          cycle_count;
    int          timeout_limit;

    execute_clk_gen i_clk_gen (
        .clk (clk)
    );

    execute i_execute (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .start_alu       (start[U_ALU]),
        .rs1_v_alu       (rs1_v[U_ALU]),
        .rs2_v_alu       (rs2_v[U_ALU]),
        .decode_info_alu (di[U_ALU]),
        .rob_idx_alu     (rob_idx[U_ALU]),
        .pd_alu          (pd[U_ALU]),
        .rd_alu          (rd[U_ALU]),
        .start_mul       (start[U_MUL]),
        .rs1_v_mul       (rs1_v[U_MUL]),
        .rs2_v_mul       (rs2_v[U_MUL]),
        .decode_info_mul (di[U_MUL]),
        .rob_idx_mul     (rob_idx[U_MUL]),
        .pd_mul          (pd[U_MUL]),
        .rd_mul          (rd[U_MUL]),
        .start_div       (start[U_DIV]),
        .rs1_v_div       (rs1_v[U_DIV]),
        .rs2_v_div       (rs2_v[U_DIV]),
        .decode_info_div (di[U_DIV]),
        .rob_idx_div     (rob_idx[U_DIV]),
        .pd_div          (pd[U_DIV]),
        .rd_div          (rd[U_DIV]),
        .start_br        (start[U_BR]),
        .rs1_v_br        (rs1_v[U_BR]),
        .rs2_v_br        (rs2_v[U_BR]),
        .decode_info_br  (di[U_BR]),
        .rob_idx_br      (rob_idx[U_BR]),
        .pd_br           (pd[U_BR]),
        .rd_br           (rd[U_BR]),
        .cdb_alu         (cdb[U_ALU]),
        .cdb_mul         (cdb[U_MUL]),
        .cdb_div         (cdb[U_DIV]),
        .cdb_br          (cdb[U_BR]),
        .busy_mul        (busy[U_MUL]),
        .busy_div        (busy[U_DIV]),
        .busy_br         (busy[U_BR])
    );

    function automatic int unit_latency(input int u);
        case (u)
            U_MUL:   return `MUL_LATENCY;
            U_DIV:   return `DIV_CYCLES;
            U_BR:    return 1;
            default: return 0;
        endcase
    endfunction

    function automatic string port_name(input int u);
        case (u)
            U_MUL:   return "cdb_mul";
            U_DIV:   return "cdb_div";
            U_BR:    return "cdb_br";
            default: return "cdb_alu";
        endcase
    endfunction

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic value_mismatch(input string field, input logic [31:0] exp,
                                  input logic [31:0] got);
        $display("Fail %s: expected %h got %h", field, exp, got);
        value_errors++;
    endtask

    task automatic protocol_error(input string what);
        $display("Error: %s", what);
        protocol_errors++;
    endtask

    // compare one cdb word against the record at base
    task automatic check_result(input int base, input string name, input cdb_t got);
        if (got.valid !== 1'b1)
            value_mismatch({name, ".valid"}, 32'h1, 32'(got.valid));
        if (got.rob_idx !== stim[base+7][`ROB_ADDR_WIDTH-1:0])
            value_mismatch({name, ".rob_idx"}, stim[base+7], 32'(got.rob_idx));
        if (got.pd !== stim[base+8][`PHYS_REG_BITS-1:0])
            value_mismatch({name, ".pd"}, stim[base+8], 32'(got.pd));
        if (got.rd !== stim[base+9][`ARCH_REG_BITS-1:0])
            value_mismatch({name, ".rd"}, stim[base+9], 32'(got.rd));
        if (got.rd_v !== stim[base+11])
            value_mismatch({name, ".rd_v"}, stim[base+11], got.rd_v);
        if (got.pc_select !== stim[base+12][0])
            value_mismatch({name, ".pc_select"}, stim[base+12], 32'(got.pc_select));
        if (got.pc_branch !== stim[base+13])
            value_mismatch({name, ".pc_branch"}, stim[base+13], got.pc_branch);
        if (got.op !== stim[base+1][5:0])
            value_mismatch({name, ".op"}, stim[base+1], 32'(got.op));
    endtask

    task automatic drive_operation(input int base, input int u);
        start[u]           = 1'b1;
        di[u].op           = exec_op_t'(stim[base+1][5:0]);
        di[u].use_imm      = stim[base+2][0];
        di[u].imm          = stim[base+3];
        di[u].pc           = stim[base+4];
        rs1_v[u]           = stim[base+5];
        rs2_v[u]           = stim[base+6];
        rob_idx[u]         = stim[base+7][`ROB_ADDR_WIDTH-1:0];
        pd[u]              = stim[base+8][`PHYS_REG_BITS-1:0];
        rd[u]              = stim[base+9][`ARCH_REG_BITS-1:0];
    endtask

    // issue inputs change once start drops, the result must come from captured values
    task automatic scramble_issue_inputs(input int u);
        di[u]      = '0;
        rs1_v[u]   = ~rs1_v[u];
        rs2_v[u]   = ~rs2_v[u];
        rob_idx[u] = ~rob_idx[u];
        pd[u]      = ~pd[u];
        rd[u]      = ~rd[u];
    endtask

    // watch a multi-cycle unit until its result shows or the window closes
    task automatic await_result(input int base, input int u);
        int lat;
        int flush_at;
        int seen;
        lat      = unit_latency(u);
        flush_at = int'(stim[base+10]);
        seen     = 0;
        for (int n = 1; n <= lat + 4 && seen == 0; n++) begin
            if (n == flush_at) begin
                flush = 1'b1;
            end
            @(negedge clk);
            if (flush_at == 0 && n <= lat && busy[u] !== 1'b1) begin
                protocol_error($sformatf("busy low %0d cycles after start on %s",
                                         n, port_name(u)));
            end
            if (cdb[u].valid === 1'b1) begin
                seen = n;
                if (flush_at != 0) begin
                    protocol_error($sformatf("%s gave a result after a flush", port_name(u)));
                end else begin
                    if (n != lat) begin
                        protocol_error($sformatf("%s result came after %0d cycles, not %0d",
                                                 port_name(u), n, lat));
                    end
                    check_result(base, port_name(u), cdb[u]);
                end
            end
            step_cycle();
            flush = 1'b0;
        end
        if (seen == 0 && flush_at == 0) begin
            protocol_error($sformatf("no result on %s within %0d cycles", port_name(u), lat + 4));
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            $display("run stopped after %0d cycles with operations still pending", cycle_count);
            $display("errors: value %0d protocol %0d", value_errors, protocol_errors);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int base;
        int u;
        int gap;
        rst             = 1'b1;
        flush           = 1'b0;
        start           = '0;
        rs1_v           = '0;
        rs2_v           = '0;
        di              = '0;
        rob_idx         = '0;
        pd              = '0;
        rd              = '0;
        value_errors    = 0;
        protocol_errors = 0;
        cycle_count     = 0;
        timeout_limit   = 0;
        void'($urandom(17));

        $readmemh("verification/execute_stim.txt", stim);
        num_recs = 0;
        while (num_recs < MAX_RECS && stim[num_recs*REC_WORDS] !== END_MARK) begin
            num_recs++;
        end
        timeout_limit = num_recs * (`DIV_CYCLES + 8) + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int r = 0; r < num_recs; r++) begin
            base = r * REC_WORDS;
            u    = int'(stim[base]);
            gap  = int'($urandom % 4);
            repeat (gap) step_cycle();
            drive_operation(base, u);
            if (u == U_ALU) begin
                // combinational unit answers in the issue cycle
                @(negedge clk);
                check_result(base, port_name(u), cdb[u]);
                step_cycle();
                start = '0;
            end else begin
                step_cycle();
                start = '0;
                scramble_issue_inputs(u);
                await_result(base, u);
            end
        end

        step_cycle();
        $display("errors: value %0d protocol %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verification/execute_assertions.sv ====
module execute_assertions
    import rv32i_types::*;
(
    input logic clk,
    input logic rst,
    input logic flush,
    input logic start_mul,
    input logic start_div,
    input logic start_br,
    input logic busy_mul,
    input logic busy_div,
    input logic busy_br,
    input cdb_t cdb_alu,
    input cdb_t cdb_mul,
    input cdb_t cdb_div,
    input cdb_t cdb_br
);

    // issue only into an idle unit
    start_mul_idle: assert property (@(posedge clk) disable iff (rst) !(start_mul && busy_mul))
        else $error("start_mul raised while busy_mul is high");
    start_div_idle: assert property (@(posedge clk) disable iff (rst) !(start_div && busy_div))
        else $error("start_div raised while busy_div is high");
    start_br_idle: assert property (@(posedge clk) disable iff (rst) !(start_br && busy_br))
        else $error("start_br raised while busy_br is high");

    // all result ports blanked while flushing
    flush_blanks_cdb: assert property (@(posedge clk) disable iff (rst)
        flush |-> !(cdb_alu.valid || cdb_mul.valid || cdb_div.valid || cdb_br.valid))
        else $error("cdb valid seen during flush");

    // multiplier reports busy the cycle after an accepted start
    mul_busy_follows: assert property (@(posedge clk) disable iff (rst)
        (start_mul && !flush) |=> busy_mul)
        else $error("busy_mul low in the cycle after start_mul");

endmodule

bind execute execute_assertions i_execute_assertions (.*);

// ==== verification/execute_clk_gen.sv ====
module execute_clk_gen (
    output logic clk
);

    // period of 8, first rising edge at 4
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

// ==== hw/execute.sv ====
`include "rv32i_params.svh"

module execute
    import rv32i_types::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,

    input  logic                         start_alu,
    input  logic [`XLEN-1:0]             rs1_v_alu,
    input  logic [`XLEN-1:0]             rs2_v_alu,
    input  decode_info_t                 decode_info_alu,
    input  logic [`ROB_ADDR_WIDTH-1:0]   rob_idx_alu,
    input  logic [`PHYS_REG_BITS-1:0]    pd_alu,
    input  logic [`ARCH_REG_BITS-1:0]    rd_alu,

    input  logic                         start_mul,
    input  logic [`XLEN-1:0]             rs1_v_mul,
    input  logic [`XLEN-1:0]             rs2_v_mul,
    input  decode_info_t                 decode_info_mul,
    input  logic [`ROB_ADDR_WIDTH-1:0]   rob_idx_mul,
    input  logic [`PHYS_REG_BITS-1:0]    pd_mul,
    input  logic [`ARCH_REG_BITS-1:0]    rd_mul,

    input  logic                         start_div,
    input  logic [`XLEN-1:0]             rs1_v_div,
    input  logic [`XLEN-1:0]             rs2_v_div,
    input  decode_info_t                 decode_info_div,
    input  logic [`ROB_ADDR_WIDTH-1:0]   rob_idx_div,
    input  logic [`PHYS_REG_BITS-1:0]    pd_div,
    input  logic [`ARCH_REG_BITS-1:0]    rd_div,

    input  logic                         start_br,
    input  logic [`XLEN-1:0]             rs1_v_br,
    input  logic [`XLEN-1:0]             rs2_v_br,
    input  decode_info_t                 decode_info_br,
    input  logic [`ROB_ADDR_WIDTH-1:0]   rob_idx_br,
    input  logic [`PHYS_REG_BITS-1:0]    pd_br,
    input  logic [`ARCH_REG_BITS-1:0]    rd_br,

    output cdb_t                         cdb_alu,
    output cdb_t                         cdb_mul,
    output cdb_t                         cdb_div,
    output cdb_t                         cdb_br,
    output logic                         busy_mul,
    output logic                         busy_div,
    output logic                         busy_br
);

    // rename tags carried alongside an operation
    typedef struct packed {
        logic [`ROB_ADDR_WIDTH-1:0]  rob_idx;
        logic [`PHYS_REG_BITS-1:0]   pd;
        logic [`ARCH_REG_BITS-1:0]   rd;
        exec_op_t                    op;
    } tag_t;

    logic                       start_alu_g, start_mul_g, start_div_g, start_br_g;
    tag_t                       tag_alu;
    tag_t                       tag_mul_q, tag_div_q, tag_br_q;
    logic [`MUL_LATENCY-1:0]    mul_sr;
    logic [`DIV_CYCLES-1:0]     div_sr;

    logic                       valid_alu, valid_mul, valid_div, valid_br;
    logic [`XLEN-1:0]           rd_v_alu, rd_v_mul, rd_v_div, rd_v_br;
    logic                       pc_select_br;
    logic [`XLEN-1:0]           pc_branch_br;

    function automatic cdb_t pack_cdb(
        input logic              vld,
        input tag_t              tag,
        input logic [`XLEN-1:0]  value,
        input logic              sel,
        input logic [`XLEN-1:0]  target
    );
        cdb_t c;
        c.valid     = vld;
        c.rob_idx   = tag.rob_idx;
        c.pd        = tag.pd;
        c.rd        = tag.rd;
        c.rd_v      = value;
        c.pc_select = sel;
        c.pc_branch = target;
        c.op        = tag.op;
        return c;
    endfunction

    // no issue while flushing
    assign start_alu_g = start_alu & ~flush;
    assign start_mul_g = start_mul & ~flush;
    assign start_div_g = start_div & ~flush;
    assign start_br_g  = start_br & ~flush;

    assign tag_alu = {rob_idx_alu, pd_alu, rd_alu, decode_info_alu.op};

    always_ff @(posedge clk) begin
        if (start_mul_g) begin
            tag_mul_q <= {rob_idx_mul, pd_mul, rd_mul, decode_info_mul.op};
        end
        if (start_div_g) begin
            tag_div_q <= {rob_idx_div, pd_div, rd_div, decode_info_div.op};
        end
        if (start_br_g) begin
            tag_br_q <= {rob_idx_br, pd_br, rd_br, decode_info_br.op};
        end
    end

    // one bit per in-flight cycle, the last one lines up with valid
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mul_sr <= '0;
            div_sr <= '0;
        end else begin
            mul_sr <= {mul_sr[`MUL_LATENCY-2:0], start_mul_g};
            div_sr <= {div_sr[`DIV_CYCLES-2:0], start_div_g};
        end
    end

    assign busy_mul = |mul_sr;
    assign busy_div = |div_sr;

    fu_alu i_fu_alu (
        .decode_info (decode_info_alu),
        .rs1_v       (rs1_v_alu),
        .rs2_v       (rs2_v_alu),
        .start       (start_alu_g),
        .rd_v        (rd_v_alu),
        .valid       (valid_alu)
    );

    fu_mult i_fu_mult (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .start       (start_mul_g),
        .decode_info (decode_info_mul),
        .rs1_v       (rs1_v_mul),
        .rs2_v       (rs2_v_mul),
        .rd_v        (rd_v_mul),
        .valid       (valid_mul)
    );

    fu_div_rem i_fu_div_rem (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .start       (start_div_g),
        .decode_info (decode_info_div),
        .rs1_v       (rs1_v_div),
        .rs2_v       (rs2_v_div),
        .rd_v        (rd_v_div),
        .valid       (valid_div)
    );

    fu_br i_fu_br (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .start       (start_br_g),
        .decode_info (decode_info_br),
        .rs1_v       (rs1_v_br),
        .rs2_v       (rs2_v_br),
        .rd_v        (rd_v_br),
        .pc_branch   (pc_branch_br),
        .pc_select   (pc_select_br),
        .valid       (valid_br),
        .busy        (busy_br)
    );

    // ALU uses live tags, the rest use tags captured at issue
    always_comb begin
        if (flush) begin
            cdb_alu = '0;
            cdb_mul = '0;
            cdb_div = '0;
            cdb_br  = '0;
        end else begin
            cdb_alu = pack_cdb(valid_alu, tag_alu, rd_v_alu, 1'b0, '0);
            cdb_mul = pack_cdb(valid_mul, tag_mul_q, rd_v_mul, 1'b0, '0);
            cdb_div = pack_cdb(valid_div, tag_div_q, rd_v_div, 1'b0, '0);
            cdb_br  = pack_cdb(valid_br, tag_br_q, rd_v_br, pc_select_br, pc_branch_br);
        end
    end

endmodule

// ==== hw/fu_br.sv ====
`include "rv32i_params.svh"

module fu_br
    import rv32i_types::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               start,
    input  decode_info_t       decode_info,
    input  logic [`XLEN-1:0]   rs1_v,
    input  logic [`XLEN-1:0]   rs2_v,
    output logic [`XLEN-1:0]   rd_v,
    output logic [`XLEN-1:0]   pc_branch,
    output logic               pc_select,
    output logic               valid,
    output logic               busy
);

    logic               taken;
    logic               is_jump;
    logic [`XLEN-1:0]   target;
    logic [`XLEN-1:0]   jalr_sum;

    assign is_jump  = decode_info.op inside {JAL, JALR};
    assign jalr_sum = rs1_v + decode_info.imm;

    always_comb begin
        case (decode_info.op)
            BEQ:       taken = (rs1_v == rs2_v);
            BNE:       taken = (rs1_v != rs2_v);
            BLT:       taken = $signed(rs1_v) < $signed(rs2_v);
            BGE:       taken = $signed(rs1_v) >= $signed(rs2_v);
            BLTU:      taken = rs1_v < rs2_v;
            BGEU:      taken = rs1_v >= rs2_v;
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // JALR clears bit 0 of rs1 + imm
    assign target = (decode_info.op == JALR) ? {jalr_sum[`XLEN-1:1], 1'b0}
                                             : decode_info.pc + decode_info.imm;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= 1'b0;
        end else begin
            valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pc_select <= taken;
            pc_branch <= target;
            // link value only for jumps
            rd_v      <= is_jump ? decode_info.pc + `XLEN'd4 : '0;
        end
    end

    // one-cycle unit, busy only while the result is out
    assign busy = valid;

endmodule

// ==== hw/fu_div_rem.sv ====
`include "rv32i_params.svh"

module fu_div_rem
    import rv32i_types::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               start,
    input  decode_info_t       decode_info,
    input  logic [`XLEN-1:0]   rs1_v,
    input  logic [`XLEN-1:0]   rs2_v,
    output logic [`XLEN-1:0]   rd_v,
    output logic               valid
);

    div_state_t          state;
    logic [4:0]          count;
    logic [`XLEN-1:0]    rem_acc;
    logic [`XLEN-1:0]    quo;
    logic [`XLEN-1:0]    divisor;
    logic [`XLEN-1:0]    dividend;
    logic                neg_q;
    logic                neg_r;
    logic                want_rem;
    logic                div_zero;
    logic                is_signed;
    logic [`XLEN:0]      shifted;
    logic [`XLEN:0]      trial;
    logic                fits;
    logic [`XLEN-1:0]    q_fix;
    logic [`XLEN-1:0]    r_fix;

    assign is_signed = decode_info.op inside {DIV, REM};

    // next dividend bit shifts into the partial remainder
    assign shifted = {rem_acc, quo[`XLEN-1]};
    assign fits    = shifted >= {1'b0, divisor};
    assign trial   = shifted - {1'b0, divisor};

    // most negative / -1 lands on the dividend with no special case
    assign q_fix = neg_q ? -quo : quo;
    assign r_fix = neg_r ? -rem_acc : rem_acc;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= IDLE;
            count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        dividend <= rs1_v;
                        quo      <= (is_signed && rs1_v[`XLEN-1]) ? -rs1_v : rs1_v;
                        divisor  <= (is_signed && rs2_v[`XLEN-1]) ? -rs2_v : rs2_v;
                        rem_acc  <= '0;
                        neg_q    <= is_signed && (rs1_v[`XLEN-1] ^ rs2_v[`XLEN-1]);
                        neg_r    <= is_signed && rs1_v[`XLEN-1];
                        want_rem <= decode_info.op inside {REM, REMU};
                        div_zero <= (rs2_v == '0);
                        count    <= '0;
                        state    <= RUN;
                    end
                end
                RUN: begin
                    // restoring step, keep the shifted value if the divisor does not fit
                    rem_acc <= fits ? trial[`XLEN-1:0] : shifted[`XLEN-1:0];
                    quo     <= {quo[`XLEN-2:0], fits};
                    count   <= count + 5'd1;
                    if (count == 5'd31) begin
                        state <= FIXUP;
                    end
                end
                FIXUP: begin
                    // x/0 gives all ones and remainder x
                    if (div_zero) begin
                        rd_v <= want_rem ? dividend : '1;
                    end else begin
                        rd_v <= want_rem ? r_fix : q_fix;
                    end
                    state <= DONE;
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign valid = (state == DONE);

endmodule

// ==== hw/fu_mult.sv ====
`include "rv32i_params.svh"

module fu_mult
    import rv32i_types::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               start,
    input  decode_info_t       decode_info,
    input  logic [`XLEN-1:0]   rs1_v,
    input  logic [`XLEN-1:0]   rs2_v,
    output logic [`XLEN-1:0]   rd_v,
    output logic               valid
);

    logic                      a_signed;
    logic                      b_signed;
    logic [`XLEN:0]            a_ext;
    logic [`XLEN:0]            b_ext;

    logic [`MUL_LATENCY-1:0]   stage_v;
    logic [`XLEN:0]            s1_a;
    logic [`XLEN:0]            s1_b;
    logic                      s1_hi;
    logic [2*`XLEN+1:0]        s2_prod;
    logic                      s2_hi;
    logic [`XLEN-1:0]          s3_word;
    logic [`XLEN-1:0]          s4_word;

    // MULHU zero-extends both, MULHSU only rs2
    assign a_signed = decode_info.op inside {MUL, MULH, MULHSU};
    assign b_signed = decode_info.op inside {MUL, MULH};
    assign a_ext    = {a_signed & rs1_v[`XLEN-1], rs1_v};
    assign b_ext    = {b_signed & rs2_v[`XLEN-1], rs2_v};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            stage_v <= '0;
        end else begin
            stage_v <= {stage_v[`MUL_LATENCY-2:0], start};
        end
    end

    // datapath registers, qualified by stage_v
    always_ff @(posedge clk) begin
        s1_a    <= a_ext;
        s1_b    <= b_ext;
        s1_hi   <= (decode_info.op != MUL);
        s2_prod <= $signed(s1_a) * $signed(s1_b);
        s2_hi   <= s1_hi;
        s3_word <= s2_hi ? s2_prod[2*`XLEN-1:`XLEN] : s2_prod[`XLEN-1:0];
        s4_word <= s3_word;
    end

    assign rd_v  = s4_word;
    assign valid = stage_v[`MUL_LATENCY-1];

endmodule

// ==== hw/fu_alu.sv ====
`include "rv32i_params.svh"

module fu_alu
    import rv32i_types::*;
(
    input  decode_info_t       decode_info,
    input  logic [`XLEN-1:0]   rs1_v,
    input  logic [`XLEN-1:0]   rs2_v,
    input  logic               start,
    output logic [`XLEN-1:0]   rd_v,
    output logic               valid
);

    logic [`XLEN-1:0] operand_b;
    logic [4:0]       shamt;

    // immediate forms swap in imm for rs2
    assign operand_b = decode_info.use_imm ? decode_info.imm : rs2_v;
    assign shamt     = operand_b[4:0];

    always_comb begin
        case (decode_info.op)
            ADD:     rd_v = rs1_v + operand_b;
            SUB:     rd_v = rs1_v - operand_b;
            SLL:     rd_v = rs1_v << shamt;
            SLT:     rd_v = {{(`XLEN-1){1'b0}}, $signed(rs1_v) < $signed(operand_b)};
            SLTU:    rd_v = {{(`XLEN-1){1'b0}}, rs1_v < operand_b};
            XOR:     rd_v = rs1_v ^ operand_b;
            SRL:     rd_v = rs1_v >> shamt;
            SRA:     rd_v = $signed(rs1_v) >>> shamt;
            OR:      rd_v = rs1_v | operand_b;
            AND:     rd_v = rs1_v & operand_b;
            // imm already holds the upper-immediate value
            LUI:     rd_v = decode_info.imm;
            AUIPC:   rd_v = decode_info.pc + decode_info.imm;
            default: rd_v = '0;
        endcase
    end

    // single-cycle unit, result in the issue cycle
    assign valid = start;

endmodule

// ==== hw/rv32i_types.sv ====
`include "rv32i_params.svh"

package rv32i_types;

    // grouped by functional unit
    typedef enum logic [5:0] {
        ADD    = 6'h00,
        SUB    = 6'h01,
        SLL    = 6'h02,
        SLT    = 6'h03,
        SLTU   = 6'h04,
        XOR    = 6'h05,
        SRL    = 6'h06,
        SRA    = 6'h07,
        OR     = 6'h08,
        AND    = 6'h09,
        LUI    = 6'h0a,
        AUIPC  = 6'h0b,
        MUL    = 6'h10,
        MULH   = 6'h11,
        MULHSU = 6'h12,
        MULHU  = 6'h13,
        DIV    = 6'h18,
        DIVU   = 6'h19,
        REM    = 6'h1a,
        REMU   = 6'h1b,
        BEQ    = 6'h20,
        BNE    = 6'h21,
        BLT    = 6'h22,
        BGE    = 6'h23,
        BLTU   = 6'h24,
        BGEU   = 6'h25,
        JAL    = 6'h26,
        JALR   = 6'h27
    } exec_op_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIXUP,
        DONE
    } div_state_t;

    typedef struct packed {
        exec_op_t              op;
        logic                  use_imm;
        logic [`XLEN-1:0]      imm;
        logic [`XLEN-1:0]      pc;
    } decode_info_t;

    // one result broadcast
    typedef struct packed {
        logic                        valid;
        logic [`ROB_ADDR_WIDTH-1:0]  rob_idx;
        logic [`PHYS_REG_BITS-1:0]   pd;
        logic [`ARCH_REG_BITS-1:0]   rd;
        logic [`XLEN-1:0]            rd_v;
        logic                        pc_select;
        logic [`XLEN-1:0]            pc_branch;
        // ROB checks this at commit
        exec_op_t                    op;
    } cdb_t;

endpackage

// ==== include/rv32i_params.svh ====
`ifndef RV32I_PARAMS_SVH
`define RV32I_PARAMS_SVH

// rename tag widths
`define ROB_ADDR_WIDTH 5
`define PHYS_REG_BITS 6
`define ARCH_REG_BITS 5

// datapath width
`define XLEN 32

// multiplier pipeline depth, start edge to result
`define MUL_LATENCY 4

// load + 32 iterations + sign fix-up
`define DIV_CYCLES 34

`endif
